// File: rtl/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// data and address width of the base ISA
`define RV_XLEN   32

// x0..x31
`define RV_REG_AW 5

`endif

// File: rtl/rv_isa_pkg.sv
`include "rv_decode_defines.svh"

package rv_isa_pkg;

    // major opcodes, bits [6:2] of the word
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    localparam logic [1:0] OPC_FULL = 2'b11;  // low bits of a 32-bit encoding

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [4:0]            op;
        logic [1:0]            quad;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;  // also funct12 for system words
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // one word, register view or immediate views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

endpackage

// File: rtl/rv_ctrl_pkg.sv
`include "rv_decode_defines.svh"

package rv_ctrl_pkg;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        rv_isa_pkg::rv_inst_u inst;
    } fetch_t;

    typedef struct packed {
        logic pc;
        logic r;
    } op1_src_t;

    typedef struct packed {
        logic j;
        logic i;
        logic r;
    } op2_src_t;

    typedef struct packed {
        logic memory;
        logic pc_p4;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic res_cmp;
        logic res_bits;
        logic res_shift;
        logic res_arith;
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed {
        logic inst_lb, inst_lh, inst_lw, inst_lbu, inst_lhu;
        logic inst_addi, inst_slli, inst_slti, inst_sltiu, inst_xori;
        logic inst_srli, inst_srai, inst_ori, inst_andi;
        logic inst_sb, inst_sh, inst_sw;
        logic inst_add, inst_sub, inst_sll, inst_slt, inst_sltu;
        logic inst_xor, inst_srl, inst_sra, inst_or, inst_and;
        logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
        logic inst_lui, inst_auipc, inst_jal, inst_jalr;
        logic inst_fence, inst_fence_i, inst_ecall, inst_ebreak;
        // opcode groups
        logic inst_load, inst_store, inst_imm, inst_reg, inst_branch;
        logic inst_slts, inst_ltu;
        logic inst_none;       // all-zero word
        logic inst_supported;
    } inst_class_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm_i;
        logic [`RV_XLEN-1:0]   imm_j;  // jal or branch offset
        logic [2:0]            funct3;
        logic                  reg_write;
        op1_src_t              op1_src;
        op2_src_t              op2_src;
        res_src_t              res_src;
        alu_ctrl_t             alu_ctrl;
        logic                  inst_jalr;
        logic                  inst_jal;
        logic                  inst_branch;
        logic                  inst_store;
        logic                  inst_supported;
    } decode_t;

endpackage

// File: rtl/rv_inst_class.sv
module rv_inst_class (
    input  rv_isa_pkg::rv_inst_u     i_inst,
    output rv_ctrl_pkg::inst_class_t o_class
);
    import rv_isa_pkg::*;

    logic [4:0] op;
    logic [2:0] f3;
    logic       full;
    logic       f7_base;
    logic       f7_alt;
    logic       op_load, op_mem, op_imm, op_store, op_reg, op_branch, op_sys;

    assign op      = i_inst.r.op;
    assign f3      = i_inst.r.funct3;
    assign full    = (i_inst.r.quad == OPC_FULL);
    assign f7_base = (i_inst.r.funct7 == F7_BASE);
    assign f7_alt  = (i_inst.r.funct7 == F7_ALT);

    assign op_load   = full & (op == LOAD);
    assign op_mem    = full & (op == MISC_MEM);
    assign op_imm    = full & (op == OP_IMM);
    assign op_store  = full & (op == STORE);
    assign op_reg    = full & (op == OP);
    assign op_branch = full & (op == BRANCH);
    assign op_sys    = full & (op == SYSTEM);

    assign o_class.inst_lb     = op_load & (f3 == 3'b000);
    assign o_class.inst_lh     = op_load & (f3 == 3'b001);
    assign o_class.inst_lw     = op_load & (f3 == 3'b010);
    assign o_class.inst_lbu    = op_load & (f3 == 3'b100);
    assign o_class.inst_lhu    = op_load & (f3 == 3'b101);

    assign o_class.inst_addi   = op_imm & (f3 == 3'b000);
    assign o_class.inst_slli   = op_imm & (f3 == 3'b001);
    assign o_class.inst_slti   = op_imm & (f3 == 3'b010);
    assign o_class.inst_sltiu  = op_imm & (f3 == 3'b011);
    assign o_class.inst_xori   = op_imm & (f3 == 3'b100);
    assign o_class.inst_srli   = op_imm & (f3 == 3'b101) & f7_base;
    assign o_class.inst_srai   = op_imm & (f3 == 3'b101) & f7_alt;
    assign o_class.inst_ori    = op_imm & (f3 == 3'b110);
    assign o_class.inst_andi   = op_imm & (f3 == 3'b111);

    assign o_class.inst_sb     = op_store & (f3 == 3'b000);
    assign o_class.inst_sh     = op_store & (f3 == 3'b001);
    assign o_class.inst_sw     = op_store & (f3 == 3'b010);

    assign o_class.inst_add    = op_reg & (f3 == 3'b000) & f7_base;
    assign o_class.inst_sub    = op_reg & (f3 == 3'b000) & f7_alt;
    assign o_class.inst_sll    = op_reg & (f3 == 3'b001) & f7_base;
    assign o_class.inst_slt    = op_reg & (f3 == 3'b010) & f7_base;
    assign o_class.inst_sltu   = op_reg & (f3 == 3'b011) & f7_base;
    assign o_class.inst_xor    = op_reg & (f3 == 3'b100) & f7_base;
    assign o_class.inst_srl    = op_reg & (f3 == 3'b101) & f7_base;
    assign o_class.inst_sra    = op_reg & (f3 == 3'b101) & f7_alt;
    assign o_class.inst_or     = op_reg & (f3 == 3'b110) & f7_base;
    assign o_class.inst_and    = op_reg & (f3 == 3'b111) & f7_base;

    assign o_class.inst_beq    = op_branch & (f3 == 3'b000);
    assign o_class.inst_bne    = op_branch & (f3 == 3'b001);
    assign o_class.inst_blt    = op_branch & (f3 == 3'b100);
    assign o_class.inst_bge    = op_branch & (f3 == 3'b101);
    assign o_class.inst_bltu   = op_branch & (f3 == 3'b110);
    assign o_class.inst_bgeu   = op_branch & (f3 == 3'b111);

    assign o_class.inst_lui    = full & (op == LUI);
    assign o_class.inst_auipc  = full & (op == AUIPC);
    assign o_class.inst_jal    = full & (op == JAL);
    assign o_class.inst_jalr   = full & (op == JALR) & (f3 == 3'b000);

    assign o_class.inst_fence   = op_mem & (f3 == 3'b000);
    assign o_class.inst_fence_i = op_mem & (f3 == 3'b001);
    // funct12 selects between the two
    assign o_class.inst_ecall   = op_sys & (f3 == 3'b000) & (i_inst.i.imm == 12'h000);
    assign o_class.inst_ebreak  = op_sys & (f3 == 3'b000) & (i_inst.i.imm == 12'h001);

    // groups follow the opcode only, funct bits not checked
    assign o_class.inst_load   = op_load;
    assign o_class.inst_store  = op_store;
    assign o_class.inst_imm    = op_imm;
    assign o_class.inst_reg    = op_reg;
    assign o_class.inst_branch = op_branch;
    assign o_class.inst_slts   = (op_imm | (op_reg & f7_base)) & (f3[2:1] == 2'b01);
    assign o_class.inst_ltu    = ((op_imm | (op_reg & f7_base)) & (f3 == 3'b011)) |
                                 (op_branch & (f3[2:1] == 2'b11));
    assign o_class.inst_none   = ~|i_inst;  // bubble

    // ecall and ebreak stay unsupported
    assign o_class.inst_supported =
        o_class.inst_none  |
        o_class.inst_lb    | o_class.inst_lh   | o_class.inst_lw   | o_class.inst_lbu   |
        o_class.inst_lhu   | o_class.inst_addi | o_class.inst_slli | o_class.inst_slti  |
        o_class.inst_sltiu | o_class.inst_xori | o_class.inst_srli | o_class.inst_srai  |
        o_class.inst_ori   | o_class.inst_andi | o_class.inst_sb   | o_class.inst_sh    |
        o_class.inst_sw    | o_class.inst_add  | o_class.inst_sub  | o_class.inst_sll   |
        o_class.inst_slt   | o_class.inst_sltu | o_class.inst_xor  | o_class.inst_srl   |
        o_class.inst_sra   | o_class.inst_or   | o_class.inst_and  | o_class.inst_beq   |
        o_class.inst_bne   | o_class.inst_blt  | o_class.inst_bge  | o_class.inst_bltu  |
        o_class.inst_bgeu  | o_class.inst_lui  | o_class.inst_auipc | o_class.inst_jal  |
        o_class.inst_jalr  | o_class.inst_fence | o_class.inst_fence_i;

endmodule

// File: rtl/rv_imm_gen.sv
`include "rv_decode_defines.svh"

module rv_imm_gen (
    input  rv_isa_pkg::rv_inst_u     i_inst,
    input  rv_ctrl_pkg::inst_class_t i_class,
    output logic [`RV_XLEN-1:0]      o_imm_i,
    output logic [`RV_XLEN-1:0]      o_imm_j
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign imm_i = {{(`RV_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
    assign imm_s = {{(`RV_XLEN-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
    assign imm_u = {i_inst.u.imm_31_12, 12'b0};

    // offsets are in halfwords, bit 0 always clear
    assign imm_b = {{(`RV_XLEN-12){i_inst.b.imm_12}}, i_inst.b.imm_11,
                    i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
    assign imm_j = {{(`RV_XLEN-20){i_inst.j.imm_20}}, i_inst.j.imm_19_12,
                    i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

    always_comb begin
        if (i_class.inst_lui | i_class.inst_auipc) begin
            o_imm_i = imm_u;
        end else if (i_class.inst_store) begin
            o_imm_i = imm_s;
        end else begin
            o_imm_i = imm_i;  // also jalr and loads
        end
    end

    assign o_imm_j = i_class.inst_jal ? imm_j : imm_b;

endmodule

// File: rtl/rv_ctrl_gen.sv
module rv_ctrl_gen (
    input  rv_ctrl_pkg::inst_class_t i_class,
    input  logic [2:0]               i_funct3,
    output rv_ctrl_pkg::decode_t     o_ctrl
);

    logic pc_op1;   // auipc, jal
    logic imm_op2;
    logic link;     // writes pc+4

    assign pc_op1  = i_class.inst_auipc | i_class.inst_jal;
    assign imm_op2 = i_class.inst_jalr | i_class.inst_load | i_class.inst_imm |
                     i_class.inst_lui | i_class.inst_auipc | i_class.inst_store;
    assign link    = i_class.inst_jalr | i_class.inst_jal;

    always_comb begin
        o_ctrl = '0;  // pc, registers, immediates and funct3 filled at the top

        o_ctrl.reg_write = i_class.inst_load | i_class.inst_imm | i_class.inst_auipc |
                           i_class.inst_reg | i_class.inst_lui | link;

        o_ctrl.op1_src.pc = pc_op1;
        o_ctrl.op1_src.r  = ~pc_op1;
        o_ctrl.op2_src.j  = i_class.inst_jal;
        o_ctrl.op2_src.i  = imm_op2;
        o_ctrl.op2_src.r  = ~(imm_op2 | i_class.inst_jal);

        o_ctrl.res_src.memory = i_class.inst_load;
        o_ctrl.res_src.pc_p4  = link;
        o_ctrl.res_src.alu    = ~(i_class.inst_load | link);

        o_ctrl.alu_ctrl.res_cmp   = i_class.inst_branch | i_class.inst_slts;
        o_ctrl.alu_ctrl.res_bits  = i_class.inst_andi | i_class.inst_and |
                                    i_class.inst_ori | i_class.inst_or |
                                    i_class.inst_xori | i_class.inst_xor;
        o_ctrl.alu_ctrl.res_shift = i_class.inst_slli | i_class.inst_sll |
                                    i_class.inst_srli | i_class.inst_srl |
                                    i_class.inst_srai | i_class.inst_sra;
        o_ctrl.alu_ctrl.res_arith = i_class.inst_sub | i_class.inst_add;

        o_ctrl.alu_ctrl.cmp_eq  = i_class.inst_beq | i_class.inst_bne;
        o_ctrl.alu_ctrl.cmp_lts = i_class.inst_slti | i_class.inst_slt |
                                  i_class.inst_blt | i_class.inst_bge;
        o_ctrl.alu_ctrl.cmp_ltu = i_class.inst_ltu;
        o_ctrl.alu_ctrl.cmp_inversed = i_funct3[0] & i_class.inst_branch;  // bne, bge, bgeu

        o_ctrl.alu_ctrl.bits_and  = i_class.inst_andi | i_class.inst_and;
        o_ctrl.alu_ctrl.bits_or   = i_class.inst_ori | i_class.inst_or;
        o_ctrl.alu_ctrl.bits_xor  = i_class.inst_xori | i_class.inst_xor;
        o_ctrl.alu_ctrl.arith_shl = i_class.inst_slli | i_class.inst_sll;
        o_ctrl.alu_ctrl.arith_shr = i_class.inst_srli | i_class.inst_srl |
                                    i_class.inst_srai | i_class.inst_sra;
        o_ctrl.alu_ctrl.arith_sub = i_class.inst_sub;
        o_ctrl.alu_ctrl.arith_add = i_class.inst_add | i_class.inst_addi;
        o_ctrl.alu_ctrl.shift_arithmetical = i_class.inst_srai | i_class.inst_sra;

        o_ctrl.inst_jalr      = i_class.inst_jalr;
        o_ctrl.inst_jal       = i_class.inst_jal;
        o_ctrl.inst_branch    = i_class.inst_branch;
        o_ctrl.inst_store     = i_class.inst_store;
        o_ctrl.inst_supported = i_class.inst_supported;
    end

endmodule

// File: rtl/rv_decode.sv
`include "rv_decode_defines.svh"

module rv_decode (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    output logic                 o_ready,
    input  rv_ctrl_pkg::fetch_t  i_fetch,
    output logic                 o_valid,
    input  logic                 i_ready,
    output rv_ctrl_pkg::decode_t o_dec
);
    import rv_ctrl_pkg::*;

    inst_class_t         cls;
    decode_t             ctrl;
    decode_t             dec_next;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_j;
    logic                take;

    rv_inst_class u_class (
        .i_inst  (i_fetch.inst),
        .o_class (cls)
    );

    rv_imm_gen u_imm (
        .i_inst  (i_fetch.inst),
        .i_class (cls),
        .o_imm_i (imm_i),
        .o_imm_j (imm_j)
    );

    rv_ctrl_gen u_ctrl (
        .i_class  (cls),
        .i_funct3 (i_fetch.inst.r.funct3),
        .o_ctrl   (ctrl)
    );

    always_comb begin
        dec_next        = ctrl;
        dec_next.pc     = i_fetch.pc;
        dec_next.rd     = i_fetch.inst.r.rd;
        dec_next.rs1    = cls.inst_lui ? '0 : i_fetch.inst.r.rs1;  // lui adds to x0
        dec_next.rs2    = i_fetch.inst.r.rs2;
        dec_next.imm_i  = imm_i;
        dec_next.imm_j  = imm_j;
        dec_next.funct3 = i_fetch.inst.r.funct3;
    end

    // single slot, refills on the edge it drains
    assign o_ready = ~o_valid | i_ready;
    assign take    = i_valid & o_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_dec <= dec_next;
        end
    end

endmodule

// File: tests/rv_decode_chk.sv
module rv_decode_chk (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_in_ready,
    input  logic                 i_out_valid,
    input  logic                 i_out_ready,
    input  rv_ctrl_pkg::decode_t i_dec
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // read by the testbench at the end

    a_reset_clear: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_out_valid)
        else begin
            fail_count++;
            $error("o_valid high right after reset");
        end

    // held record under back-pressure
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_dec))
        else begin
            fail_count++;
            $error("o_dec or o_valid changed while stalled");
        end

    a_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_in_ready == (!i_out_valid || i_out_ready))
        else begin
            fail_count++;
            $error("o_ready does not follow o_valid and i_ready");
        end

endmodule

bind rv_decode rv_decode_chk u_chk (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_in_ready  (o_ready),
    .i_out_valid (o_valid),
    .i_out_ready (i_ready),
    .i_dec       (o_dec)
);

// File: tests/rv_decode_mon.sv
module rv_decode_mon (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_in_valid,
    input  logic                 i_in_ready,
    input  logic                 i_out_valid,
    input  logic                 i_out_ready,
    input  rv_ctrl_pkg::decode_t i_dec,
    input  rv_ctrl_pkg::decode_t i_exp,
    output int                   o_mismatches,
    output int                   o_protocol,
    output int                   o_pending
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_ctrl_pkg::*;

    decode_t expq[$];  // in acceptance order
    decode_t want;

    initial begin
        o_mismatches = 0;
        o_protocol   = 0;
        o_pending    = 0;
    end

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            o_mismatches++;
            $display("FAIL t=%0t o_dec.%s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic compare(input decode_t e, input decode_t a);
        check_field("pc", e.pc, a.pc);
        check_field("rd", 32'(e.rd), 32'(a.rd));
        check_field("rs1", 32'(e.rs1), 32'(a.rs1));
        check_field("rs2", 32'(e.rs2), 32'(a.rs2));
        check_field("imm_i", e.imm_i, a.imm_i);
        check_field("imm_j", e.imm_j, a.imm_j);
        check_field("funct3", 32'(e.funct3), 32'(a.funct3));
        check_field("reg_write", 32'(e.reg_write), 32'(a.reg_write));
        check_field("op1_src", 32'(e.op1_src), 32'(a.op1_src));
        check_field("op2_src", 32'(e.op2_src), 32'(a.op2_src));
        check_field("res_src", 32'(e.res_src), 32'(a.res_src));
        check_field("alu_ctrl", 32'(e.alu_ctrl), 32'(a.alu_ctrl));
        check_field("inst_jalr", 32'(e.inst_jalr), 32'(a.inst_jalr));
        check_field("inst_jal", 32'(e.inst_jal), 32'(a.inst_jal));
        check_field("inst_branch", 32'(e.inst_branch), 32'(a.inst_branch));
        check_field("inst_store", 32'(e.inst_store), 32'(a.inst_store));
        check_field("inst_supported", 32'(e.inst_supported), 32'(a.inst_supported));
    endtask

    // pop before push, an accepted word leaves one edge later at the earliest
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            if (i_out_valid && i_out_ready) begin
                if (expq.size() == 0) begin
                    o_protocol++;
                    $display("output taken at t=%0t with no word pending", $time);
                end else begin
                    want = expq.pop_front();
                    compare(want, i_dec);
                end
            end
            if (i_in_valid && i_in_ready) begin
                expq.push_back(i_exp);
            end
            o_pending = expq.size();
        end
    end

endmodule

// File: tests/tb_rv_decode.sv
module tb_rv_decode;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_ctrl_pkg::*;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_valid;
    logic        o_ready;
    fetch_t      i_fetch;
    logic        o_valid;
    logic        i_ready;
    decode_t     o_dec;
    decode_t     exp_dec;
    logic [31:0] words[$];
    logic [4:0]  majors[11];
    int          limit;
    int          cycles;
    int          mismatches;
    int          protocol;
    int          pending;
    int          hangs;

    rv_decode i_dut (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_fetch (i_fetch),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_dec   (o_dec)
    );

    rv_decode_mon u_mon (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_in_valid   (i_valid),
        .i_in_ready   (o_ready),
        .i_out_valid  (o_valid),
        .i_out_ready  (i_ready),
        .i_dec        (o_dec),
        .i_exp        (exp_dec),
        .o_mismatches (mismatches),
        .o_protocol   (protocol),
        .o_pending    (pending)
    );

    always #20 i_clk = ~i_clk;

    function automatic decode_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
        decode_t    d;
        logic [4:0] op;
        logic [2:0] f3;
        logic       full, base, alt, ld, im, st, rg, rgb, br, lui, aui, jal, jalr;
        logic       shl, shr, sub, slts, ltu;
        op   = w[6:2];
        f3   = w[14:12];
        full = w[1:0] == 2'b11;
        base = w[31:25] == 7'h00;
        alt  = w[31:25] == 7'h20;
        ld   = full && op == 5'b00000;
        im   = full && op == 5'b00100;
        st   = full && op == 5'b01000;
        rg   = full && op == 5'b01100;
        br   = full && op == 5'b11000;
        lui  = full && op == 5'b01101;
        aui  = full && op == 5'b00101;
        jal  = full && op == 5'b11011;
        jalr = full && op == 5'b11001 && f3 == 3'd0;
        rgb  = rg && base;
        shl  = (im || rgb) && f3 == 3'd1;  // slli ignores funct7
        shr  = (im || rg) && f3 == 3'd5 && (base || alt);
        sub  = rg && alt && f3 == 3'd0;
        slts = (im || rgb) && f3[2:1] == 2'b01;
        ltu  = ((im || rgb) && f3 == 3'd3) || (br && f3[2:1] == 2'b11);
        d = '0;
        d.pc     = pc;
        d.rd     = w[11:7];
        d.rs1    = lui ? 5'd0 : w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = f3;
        if (lui || aui) begin
            d.imm_i = {w[31:12], 12'b0};
        end else if (st) begin
            d.imm_i = {{20{w[31]}}, w[31:25], w[11:7]};
        end else begin
            d.imm_i = {{20{w[31]}}, w[31:20]};
        end
        if (jal) begin
            d.imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else begin
            d.imm_j = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        d.reg_write      = ld || im || aui || rg || lui || jal || jalr;
        d.op1_src.pc     = aui || jal;
        d.op1_src.r      = !(aui || jal);
        d.op2_src.j      = jal;
        d.op2_src.i      = jalr || ld || im || lui || aui || st;
        d.op2_src.r      = !(d.op2_src.i || jal);
        d.res_src.memory = ld;
        d.res_src.pc_p4  = jal || jalr;
        d.res_src.alu    = !(ld || jal || jalr);
        d.alu_ctrl.bits_and  = (im || rgb) && f3 == 3'd7;
        d.alu_ctrl.bits_or   = (im || rgb) && f3 == 3'd6;
        d.alu_ctrl.bits_xor  = (im || rgb) && f3 == 3'd4;
        d.alu_ctrl.res_bits  = (im || rgb) && (f3 == 3'd4 || f3[2:1] == 2'b11);
        d.alu_ctrl.res_cmp   = br || slts;
        d.alu_ctrl.res_shift = shl || shr;
        d.alu_ctrl.res_arith = sub || (rgb && f3 == 3'd0);  // addi not here
        d.alu_ctrl.cmp_eq    = br && f3[2:1] == 2'b00;
        d.alu_ctrl.cmp_lts   = ((im || rgb) && f3 == 3'd2) || (br && f3[2:1] == 2'b10);
        d.alu_ctrl.cmp_ltu   = ltu;
        d.alu_ctrl.cmp_inversed = br && f3[0];
        d.alu_ctrl.arith_shl = shl;
        d.alu_ctrl.arith_shr = shr;
        d.alu_ctrl.arith_sub = sub;
        d.alu_ctrl.arith_add = (im || rgb) && f3 == 3'd0;
        d.alu_ctrl.shift_arithmetical = shr && alt;
        d.inst_jalr   = jalr;
        d.inst_jal    = jal;
        d.inst_branch = br;
        d.inst_store  = st;
        // ecall and ebreak fall outside every term
        d.inst_supported = (w == 32'd0) || lui || aui || jal || jalr || rgb
            || (ld && f3 != 3'd3 && f3 < 3'd6) || (st && f3 < 3'd3)
            || (im && (f3 != 3'd5 || base || alt))
            || (rg && alt && (f3 == 3'd0 || f3 == 3'd5))
            || (br && f3[2:1] != 2'b01) || (full && op == 5'b00011 && f3 < 3'd2);
        return d;
    endfunction

    always_comb exp_dec = ref_decode(i_fetch.pc, i_fetch.inst);

    task automatic finish_run();
        int total;
        total = mismatches + protocol + pending + hangs + i_dut.u_chk.fail_count;
        if (pending != 0) begin
            $display("%0d decoded words never left the DUT", pending);
        end
        $display("errors: mismatch=%0d protocol=%0d leftover=%0d assertion=%0d timeout=%0d",
                 mismatches, protocol, pending, i_dut.u_chk.fail_count, hangs);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        cycles = 0;
        @(posedge i_rst_n);
        while (cycles < limit) begin
            @(posedge i_clk);
            cycles++;
        end
        hangs = 1;
        $display("timeout, run still busy after %0d cycles", limit);
        finish_run();
    end

    initial begin
        logic [31:0] w;
        logic [31:0] pc;
        int          idx;
        int          m;
        int          f;
        int          k;
        void'($urandom(12787));
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_ready = 1'b0;
        i_fetch = '0;
        hangs   = 0;
        majors  = '{5'b00000, 5'b00011, 5'b00100, 5'b00101, 5'b01000, 5'b01100,
                    5'b01101, 5'b11000, 5'b11001, 5'b11011, 5'b11100};
        // every major opcode and funct3, funct7 base, alt or random
        for (m = 0; m < 11; m++) begin
            for (f = 0; f < 8; f++) begin
                for (k = 0; k < 3; k++) begin
                    w = $urandom;
                    w[6:0]   = {majors[m], 2'b11};
                    w[14:12] = 3'(f);
                    if (k == 0) begin
                        w[31:25] = 7'h00;
                    end else if (k == 1) begin
                        w[31:25] = 7'h20;
                    end
                    words.push_back(w);
                end
            end
        end
        words.push_back(32'h0000_0073);  // ecall
        words.push_back(32'h0010_0073);  // ebreak
        words.push_back(32'h0000_0000);
        repeat (300) words.push_back($urandom);
        limit = 4 * words.size() + 100;

        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;
        pc  = 32'h0000_1000;
        idx = 0;
        while (idx < words.size()) begin
            @(negedge i_clk);
            i_valid = ($urandom % 4) != 0;
            i_ready = ($urandom % 3) != 0;
            i_fetch = {pc, words[idx]};
            @(posedge i_clk);
            if (i_valid && o_ready) begin
                idx++;
                pc = pc + 32'd4;
            end
        end
        @(negedge i_clk);
        i_valid = 1'b0;
        i_ready = 1'b1;
        while (o_valid) @(negedge i_clk);
        @(negedge i_clk);
        finish_run();
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_inst_class.sv
rtl/rv_imm_gen.sv
rtl/rv_ctrl_gen.sv
rtl/rv_decode.sv
tests/rv_decode_chk.sv
tests/rv_decode_mon.sv
tests/tb_rv_decode.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_rv_decode \
    -f verilog.f -o tb_rv_decode
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rv_decode +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
